// ==== Makefile ====
TOP := tb_rbz_texture

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f compile.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== compile.f ====
design/rbz_timing_pkg.sv
design/rbz_texture_pkg.sv
design/vga_sync.sv
design/tex_qspi_reader.sv
design/texel_lane.sv
design/wall_column_render.sv
design/rbz_texture_top.sv
tb/rbz_texture_properties.sv
tb/tb_rbz_texture.sv

// ==== design/rbz_texture_pkg.sv ====
package rbz_texture_pkg;

  // One wall slice is 64 texels, one byte each in flash
  localparam int TEXEL_COUNT = 64;

  // QSPI stream phases, all counted in clocks from csb falling
  localparam logic [9:0] TSPI_CMD_LEN      = 10'd8;  // Command bits on io0
  localparam logic [9:0] TSPI_ADDR_LEN     = 10'd24; // Address bits on io0
  localparam logic [9:0] TSPI_DUMMY_LEN    = 10'd8;  // Dummy clocks before data
  localparam logic [9:0] TSPI_PREAMBLE_LEN =
    TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN; // 40
  localparam logic [9:0] TSPI_READ_LEN     = 10'(TEXEL_COUNT * 2); // Two nibbles per texel
  localparam logic [9:0] TSPI_STREAM_LEN   = TSPI_PREAMBLE_LEN + TSPI_READ_LEN; // 168
  localparam logic [9:0] TSPI_START        = 10'd600; // hpos where csb falls

  localparam logic [7:0] TSPI_READ_CMD = 8'h6B; // Quad output fast read

  // Slice address layout, 24 bits
  //   [23:15] zero
  //   [14:13] wall id
  //   [12]    side
  //   [11:6]  texu
  //   [5:0]   texel within the slice
  // Each flash byte packs two nibbles, low plane bits first, nibble bits
  // 0 red, 1 green, 2 blue, bit 3 unused

  typedef logic [5:0]  texel_idx_t; // Texel within a slice
  typedef logic [1:0]  chan_t;      // One colour channel, two planes
  typedef logic [5:0]  rgb_t;       // {blue, green, red}
  typedef logic [1:0]  wall_id_t;
  typedef logic [23:0] tex_addr_t;

  // Texture step, fixed point with TEXV_FRAC fraction bits
  localparam int TEXV_STEP_W = 12;
  localparam int TEXV_FRAC   = 9;  // 512 per texel at unit step
  localparam int TEXV_ACC_W  = 16; // Accumulator wraps here

endpackage

// ==== design/rbz_texture_top.sv ====
module rbz_texture_top (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [3:0]                              i_tex_in,    // QSPI io3..io0
  input  rbz_texture_pkg::wall_id_t               i_wall_id,   // Slice for the next line
  input  logic                                    i_side,
  input  rbz_texture_pkg::texel_idx_t             i_texu,
  input  logic [10:0]                             i_wall_size, // Geometry for this line
  input  logic [rbz_texture_pkg::TEXV_STEP_W-1:0] i_texa,
  input  rbz_texture_pkg::rgb_t                   i_sky,
  input  rbz_texture_pkg::rgb_t                   i_floor,
  output logic                                    o_tex_csb,
  output logic                                    o_tex_sclk,
  output logic                                    o_tex_out0,
  output logic                                    o_tex_oeb0,
  output logic                                    o_hsync_n,
  output logic                                    o_vsync_n,
  output logic                                    o_hblank,
  output logic                                    o_vblank,
  output logic                                    o_hmax,
  output rbz_texture_pkg::rgb_t                   o_rgb,
  output rbz_timing_pkg::pos_t                    o_hpos,
  output rbz_timing_pkg::pos_t                    o_vpos
);

  logic                        hsync;
  logic                        vsync;
  logic                        visible;
  logic                        load_even;
  logic                        load_odd;
  logic [3:0]                  nibble;     // Bit 3 carries no colour
  rbz_texture_pkg::texel_idx_t texel;
  rbz_texture_pkg::chan_t      lane_chan [3];

  vga_sync u_vga_sync (
    .clk       (clk),
    .reset     (reset),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos),
    .o_hsync   (hsync),
    .o_vsync   (vsync),
    .o_hmax    (o_hmax),
    .o_visible (visible),
    .o_hblank  (o_hblank),
    .o_vblank  (o_vblank)
  );

  assign o_hsync_n = ~hsync; // VGA syncs are active low on the pins
  assign o_vsync_n = ~vsync;

  // Fetches the next line's slice during hblank
  tex_qspi_reader u_tex_qspi_reader (
    .clk         (clk),
    .i_hpos      (o_hpos),
    .i_wall_id   (i_wall_id),
    .i_side      (i_side),
    .i_texu      (i_texu),
    .i_tex_in    (i_tex_in),
    .o_tex_csb   (o_tex_csb),
    .o_tex_sclk  (o_tex_sclk),
    .o_tex_out0  (o_tex_out0),
    .o_tex_oeb0  (o_tex_oeb0),
    .o_load_even (load_even),
    .o_load_odd  (load_odd),
    .o_nibble    (nibble)
  );

  // Lane k holds colour channel k, 0 red 1 green 2 blue
  for (genvar k = 0; k < 3; k++) begin : g_lane
    texel_lane u_texel_lane (
      .clk         (clk),
      .i_load_even (load_even),
      .i_load_odd  (load_odd),
      .i_bit       (nibble[k]),
      .i_texel     (texel),
      .o_chan      (lane_chan[k])
    );
  end

  wall_column_render u_wall_column_render (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .i_hmax      (o_hmax),
    .i_visible   (visible),
    .i_wall_size (i_wall_size),
    .i_texa      (i_texa),
    .i_chan      (lane_chan),
    .i_sky       (i_sky),
    .i_floor     (i_floor),
    .o_texel     (texel),
    .o_rgb       (o_rgb)
  );

endmodule

// ==== design/rbz_timing_pkg.sv ====
package rbz_timing_pkg;

  // 10-bit screen coordinate, wide enough for both counters
  typedef logic [9:0] pos_t;

  // Horizontal timing, 640x480 at 25 MHz pixel clock
  localparam pos_t H_VIEW       = 10'd640; // Visible pixels per line
  localparam pos_t H_SYNC_START = 10'd656; // After 16 clocks of front porch
  localparam pos_t H_SYNC_END   = 10'd752; // 96 clocks of hsync
  localparam pos_t H_TOTAL      = 10'd800; // Clocks per line

  // Vertical timing in lines
  localparam pos_t V_VIEW       = 10'd480; // Visible lines
  localparam pos_t V_SYNC_START = 10'd490;
  localparam pos_t V_SYNC_END   = 10'd492; // Two lines of vsync
  localparam pos_t V_TOTAL      = 10'd525; // Lines per frame

  // Column centre, the wall is placed around it
  localparam pos_t HALF_VIEW    = 10'd320;

endpackage

// ==== design/tex_qspi_reader.sv ====
module tex_qspi_reader (
  input  logic                          clk,
  input  rbz_timing_pkg::pos_t          i_hpos,
  input  rbz_texture_pkg::wall_id_t     i_wall_id,
  input  logic                          i_side,
  input  rbz_texture_pkg::texel_idx_t   i_texu,
  input  logic [3:0]                    i_tex_in,
  output logic                          o_tex_csb,   // Active low
  output logic                          o_tex_sclk,
  output logic                          o_tex_out0,
  output logic                          o_tex_oeb0,  // 0 drives io0, 1 releases it
  output logic                          o_load_even, // Low plane nibble this clock
  output logic                          o_load_odd,  // High plane nibble this clock
  output logic [3:0]                    o_nibble
);

  rbz_timing_pkg::pos_t       tspi_pos;   // Stream position, wraps mod 1024
  rbz_texture_pkg::tex_addr_t slice_addr;
  logic                       in_stream;
  logic                       data_phase; // Flash is presenting nibbles
  logic [2:0]                 cmd_bit;
  logic [4:0]                 addr_bit;

  // Stream phase follows hpos, so no FSM is needed
  assign tspi_pos = i_hpos - rbz_texture_pkg::TSPI_START;

  assign in_stream  = (tspi_pos < rbz_texture_pkg::TSPI_STREAM_LEN);
  assign data_phase = (tspi_pos >= rbz_texture_pkg::TSPI_PREAMBLE_LEN) && in_stream;

  // Slice base address, no per-wall offset
  assign slice_addr = {9'd0, i_wall_id, i_side, i_texu, 6'd0};

  // Serial bit select, MSB first for both fields
  assign cmd_bit  = 3'd7 - tspi_pos[2:0];
  assign addr_bit = 5'd31 - tspi_pos[4:0]; // Valid for positions 8..31

  assign o_tex_csb = !in_stream;

  // Release io0 from the dummy phase on, flash drives all four lines then
  assign o_tex_oeb0 = (tspi_pos >= rbz_texture_pkg::TSPI_CMD_LEN +
                                   rbz_texture_pkg::TSPI_ADDR_LEN);

  always_comb begin
    if (tspi_pos < rbz_texture_pkg::TSPI_CMD_LEN) begin
      o_tex_out0 = rbz_texture_pkg::TSPI_READ_CMD[cmd_bit];
    end else if (tspi_pos < rbz_texture_pkg::TSPI_CMD_LEN +
                            rbz_texture_pkg::TSPI_ADDR_LEN) begin
      o_tex_out0 = slice_addr[addr_bit];
    end else begin
      o_tex_out0 = 1'b0; // Dummy and data phases
    end
  end

  // Inverted clock, io0 set on rising clk is stable at the next sclk rise
  assign o_tex_sclk = ~clk;

  // Even positions carry the low plane, odd ones the high plane
  assign o_load_even = data_phase && !tspi_pos[0];
  assign o_load_odd  = data_phase &&  tspi_pos[0];

  // Lanes sample this on the rising clk edge that ends the position
  assign o_nibble = i_tex_in;

endmodule

// ==== design/texel_lane.sv ====
module texel_lane (
  input  logic                        clk,
  input  logic                        i_load_even, // Shift low plane buffer
  input  logic                        i_load_odd,  // Shift high plane buffer
  input  logic                        i_bit,       // This lane's nibble bit
  input  rbz_texture_pkg::texel_idx_t i_texel,
  output rbz_texture_pkg::chan_t      o_chan
);

  // One bit per texel and plane, refilled every line
  logic [rbz_texture_pkg::TEXEL_COUNT-1:0] plane_lo;
  logic [rbz_texture_pkg::TEXEL_COUNT-1:0] plane_hi;

  // Shift in at the MSB, after 64 loads texel 0 sits at bit 0
  always_ff @(posedge clk) begin
    if (i_load_even) begin
      plane_lo <= {i_bit, plane_lo[rbz_texture_pkg::TEXEL_COUNT-1:1]};
    end
    if (i_load_odd) begin
      plane_hi <= {i_bit, plane_hi[rbz_texture_pkg::TEXEL_COUNT-1:1]};
    end
  end

  // Texel readout is a plain mux, no latency
  assign o_chan = {plane_hi[i_texel], plane_lo[i_texel]};

endmodule

// ==== design/vga_sync.sv ====
module vga_sync (
  input  logic                 clk,
  input  logic                 reset,
  output rbz_timing_pkg::pos_t o_hpos,
  output rbz_timing_pkg::pos_t o_vpos,
  output logic                 o_hsync,   // Active high
  output logic                 o_vsync,   // Active high
  output logic                 o_hmax,    // Last clock of the line
  output logic                 o_visible,
  output logic                 o_hblank,
  output logic                 o_vblank
);

  logic vmax; // Last line of the frame

  assign o_hmax = (o_hpos == rbz_timing_pkg::H_TOTAL - 10'd1);
  assign vmax   = (o_vpos == rbz_timing_pkg::V_TOTAL - 10'd1);

  // Line and frame counters, both advance without stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else begin
      o_hpos <= o_hmax ? '0 : o_hpos + 10'd1;
      if (o_hmax) begin
        o_vpos <= vmax ? '0 : o_vpos + 10'd1; // Step line at end of each line
      end
    end
  end

  // Windows decoded from the registered counters
  assign o_hsync  = (o_hpos >= rbz_timing_pkg::H_SYNC_START) &&
                    (o_hpos <  rbz_timing_pkg::H_SYNC_END);
  assign o_vsync  = (o_vpos >= rbz_timing_pkg::V_SYNC_START) &&
                    (o_vpos <  rbz_timing_pkg::V_SYNC_END);
  assign o_hblank = (o_hpos >= rbz_timing_pkg::H_VIEW);
  assign o_vblank = (o_vpos >= rbz_timing_pkg::V_VIEW);

  // Pixel is drawn only when neither blank is active
  assign o_visible = !o_hblank && !o_vblank;

endmodule

// ==== design/wall_column_render.sv ====
module wall_column_render (
  input  logic                                     clk,
  input  logic                                     reset,
  input  rbz_timing_pkg::pos_t                     i_hpos,
  input  logic                                     i_hmax,
  input  logic                                     i_visible,
  input  logic [10:0]                              i_wall_size, // Wall length in pixels
  input  logic [rbz_texture_pkg::TEXV_STEP_W-1:0]  i_texa,      // Texture step per pixel
  input  rbz_texture_pkg::chan_t                   i_chan [3],  // Red, green, blue
  input  rbz_texture_pkg::rgb_t                    i_sky,
  input  rbz_texture_pkg::rgb_t                    i_floor,
  output rbz_texture_pkg::texel_idx_t              o_texel,
  output rbz_texture_pkg::rgb_t                    o_rgb
);

  logic [rbz_texture_pkg::TEXV_ACC_W-1:0] tex_acc;    // Texture coordinate, fixed point
  logic [9:0]                             half_size;
  logic [10:0]                            hpos_ext;
  logic                                   wall_en;
  rbz_texture_pkg::rgb_t                  wall_rgb;
  rbz_texture_pkg::rgb_t                  bg_rgb;

  // Accumulator holds h * texa at pixel h
  always_ff @(posedge clk) begin
    if (reset) begin
      tex_acc <= '0;
    end else if (i_hmax) begin
      tex_acc <= '0; // Restart at the line start
    end else begin
      tex_acc <= tex_acc + rbz_texture_pkg::TEXV_ACC_W'(i_texa);
    end
  end

  // Integer part of the accumulator picks the texel, wraps every 64
  assign o_texel = tex_acc[rbz_texture_pkg::TEXV_FRAC +: 6];

  // Window centred on the screen middle
  assign half_size = i_wall_size[10:1];
  assign hpos_ext  = {1'b0, i_hpos};

  // h >= 320 - half rewritten as h + half >= 320, keeps it unsigned
  assign wall_en =
    (hpos_ext + {1'b0, half_size} >= {1'b0, rbz_timing_pkg::HALF_VIEW}) &&
    (hpos_ext < {1'b0, rbz_timing_pkg::HALF_VIEW} + {1'b0, half_size});

  // Lanes answer for o_texel, blue on top
  assign wall_rgb = {i_chan[2], i_chan[1], i_chan[0]};

  // Floor on the left half, sky on the right
  assign bg_rgb = (i_hpos < rbz_timing_pkg::HALF_VIEW) ? i_floor : i_sky;

  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;       // Black during blanking
    end else if (wall_en) begin
      o_rgb = wall_rgb;
    end else begin
      o_rgb = bg_rgb;
    end
  end

endmodule

// ==== tb/rbz_texture_properties.sv ====
module rbz_texture_properties (
  input logic clk,
  input logic i_tex_csb,
  input logic i_tex_oeb0,
  input logic i_load_even,
  input logic i_load_odd
);

  logic [8:0] low_count;      // Clocks of csb low so far
  int         fail_count = 0;

  always_ff @(posedge clk) begin
    if (i_tex_csb) begin
      low_count <= '0;
    end else begin
      low_count <= low_count + 9'd1;
    end
  end

  // Stream never outlasts 168 clocks
  assert property (@(posedge clk) !i_tex_csb |-> low_count < 9'd168)
    else begin
      fail_count = fail_count + 1;
      $error("csb low beyond 168 clocks");
    end

  // Nonzero count with csb high means a stream just ended
  assert property (@(posedge clk) (i_tex_csb && low_count != 9'd0) |-> low_count == 9'd168)
    else begin
      fail_count = fail_count + 1;
      $error("csb low period not 168 clocks");
    end

  assert property (@(posedge clk) (!i_tex_csb && low_count < 9'd32) |-> !i_tex_oeb0)
    else begin
      fail_count = fail_count + 1;
      $error("oeb0 high during command or address");
    end

  assert property (@(posedge clk) i_tex_csb |-> !(i_load_even || i_load_odd))
    else begin
      fail_count = fail_count + 1;
      $error("load strobe with csb high");
    end

endmodule

bind tex_qspi_reader rbz_texture_properties u_rbz_texture_properties (
  .clk         (clk),
  .i_tex_csb   (o_tex_csb),
  .i_tex_oeb0  (o_tex_oeb0),
  .i_load_even (o_load_even),
  .i_load_odd  (o_load_odd)
);

// ==== tb/tb_rbz_texture.sv ====
module tb_rbz_texture;

  logic                                    clk;
  logic                                    reset;
  logic [3:0]                              i_tex_in;
  rbz_texture_pkg::wall_id_t               i_wall_id;
  logic                                    i_side;
  rbz_texture_pkg::texel_idx_t             i_texu;
  logic [10:0]                             i_wall_size;
  logic [rbz_texture_pkg::TEXV_STEP_W-1:0] i_texa;
  rbz_texture_pkg::rgb_t                   i_sky;
  rbz_texture_pkg::rgb_t                   i_floor;
  logic                                    o_tex_csb;
  logic                                    o_tex_sclk;
  logic                                    o_tex_out0;
  logic                                    o_tex_oeb0;
  logic                                    o_hsync_n;
  logic                                    o_vsync_n;
  logic                                    o_hblank;
  logic                                    o_vblank;
  logic                                    o_hmax;
  rbz_texture_pkg::rgb_t                   o_rgb;
  rbz_timing_pkg::pos_t                    o_hpos;
  rbz_timing_pkg::pos_t                    o_vpos;

  logic [7:0]  tex_mem [64]; // Slice bytes served by the flash model
  logic [3:0]  flash_next;   // Nibble for the coming clock
  logic [31:0] lfsr_state;
  int          test_errs;
  int          tests_passed;
  int          tests_failed;

  rbz_texture_top u_rbz_texture_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Stream position s maps to texel (s-40)/2, low nibble first
  function automatic logic [3:0] flash_nibble(input rbz_timing_pkg::pos_t h);
    int         d;
    logic [5:0] t;
    d = int'(h) - int'(rbz_texture_pkg::TSPI_START) - int'(rbz_texture_pkg::TSPI_PREAMBLE_LEN);
    t = 6'(d / 2);
    if (d >= 0 && d < 128) return d[0] ? tex_mem[t][7:4] : tex_mem[t][3:0];
    return 4'hF; // Idle lines pulled high
  endfunction

  // Flash model looks one clock ahead, drives on the rising edge
  always @(negedge clk) begin
    flash_next <= flash_nibble((o_hpos == rbz_timing_pkg::H_TOTAL - 10'd1) ? 10'd0
                                                                          : o_hpos + 10'd1);
  end
  always @(posedge clk) begin
    i_tex_in <= flash_next;
  end

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]}; // One step per bit
    end
  endtask

  // Channel k is {high plane bit k, low plane bit k}, blue on top
  function automatic rbz_texture_pkg::rgb_t texel_rgb(input logic [7:0] b);
    return {b[6], b[2], b[5], b[1], b[4], b[0]};
  endfunction

  function automatic rbz_texture_pkg::rgb_t expected_rgb(input rbz_timing_pkg::pos_t h);
    int          half;
    logic [31:0] acc;
    logic [5:0]  idx;
    half = int'(i_wall_size) / 2;
    acc  = 32'(h) * 32'(i_texa);
    idx  = 6'((acc % 65536) / 512); // Texel wraps every 64
    if (int'(h) >= 320 - half && int'(h) < 320 + half) return texel_rgb(tex_mem[idx]);
    if (h < rbz_timing_pkg::HALF_VIEW) return i_floor;
    return i_sky;
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("mismatch %s %s expected %0h actual %0h", test, what, exp, act);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic wait_pos(input rbz_timing_pkg::pos_t h, input rbz_timing_pkg::pos_t vlim);
    for (int i = 0; i < 500000; i++) begin
      @(negedge clk);
      if (o_hpos == h && o_vpos < vlim) return;
    end
    abort_run("timeout while waiting for a screen position");
  endtask

  // Line start, new geometry, colours and slice for the fetch on this line
  task automatic setup_line(input logic [11:0] texa, input logic [10:0] ws);
    logic [31:0] r;
    wait_pos(10'd0, 10'd470);
    @(posedge clk);
    take_bits(9, r);
    i_wall_id   <= r[1:0];
    i_side      <= r[2];
    i_texu      <= r[8:3];
    take_bits(12, r);
    i_sky       <= r[5:0];
    i_floor     <= r[11:6];
    i_texa      <= texa;
    i_wall_size <= ws;
    for (int t = 0; t < 64; t++) begin
      take_bits(8, r);
      tex_mem[t] = r[7:0];
    end
  endtask

  task automatic check_line(input string name);
    rbz_texture_pkg::rgb_t exp_rgb;
    wait_pos(10'd0, 10'd480); // Line after the fetch
    for (int n = 0; n < 640; n++) begin
      exp_rgb = expected_rgb(10'(n)); // Pixel n of the line
      if (o_rgb !== exp_rgb)
        report_mismatch(name, "rgb", 32'(exp_rgb), 32'(o_rgb));
      @(negedge clk);
    end
  endtask

  task automatic sync_timing_test();
    rbz_timing_pkg::pos_t h;
    rbz_timing_pkg::pos_t v;
    logic                 exp_hs_n;
    logic                 exp_vs_n;
    logic                 exp_hmax;
    logic                 exp_hb;
    logic                 exp_vb;
    h = '0; // Counters start from zero after reset
    v = '0;
    repeat (int'(rbz_timing_pkg::H_TOTAL) * int'(rbz_timing_pkg::V_TOTAL)) begin
      @(negedge clk);
      #1; // Inside the low phase of clk
      exp_hs_n = (h < rbz_timing_pkg::H_SYNC_START || h >= rbz_timing_pkg::H_SYNC_END);
      exp_vs_n = (v < rbz_timing_pkg::V_SYNC_START || v >= rbz_timing_pkg::V_SYNC_END);
      exp_hmax = (h == rbz_timing_pkg::H_TOTAL - 10'd1);
      exp_hb   = (h >= rbz_timing_pkg::H_VIEW);
      exp_vb   = (v >= rbz_timing_pkg::V_VIEW);
      if (o_hpos !== h)
        report_mismatch("sync_timing", "hpos", 32'(h), 32'(o_hpos));
      if (o_vpos !== v)
        report_mismatch("sync_timing", "vpos", 32'(v), 32'(o_vpos));
      if (o_hsync_n !== exp_hs_n)
        report_mismatch("sync_timing", "hsync_n", 32'(exp_hs_n), 32'(o_hsync_n));
      if (o_vsync_n !== exp_vs_n)
        report_mismatch("sync_timing", "vsync_n", 32'(exp_vs_n), 32'(o_vsync_n));
      if (o_hmax !== exp_hmax)
        report_mismatch("sync_timing", "hmax", 32'(exp_hmax), 32'(o_hmax));
      if (o_hblank !== exp_hb)
        report_mismatch("sync_timing", "hblank", 32'(exp_hb), 32'(o_hblank));
      if (o_vblank !== exp_vb)
        report_mismatch("sync_timing", "vblank", 32'(exp_vb), 32'(o_vblank));
      if ((exp_hb || exp_vb) && o_rgb !== 6'd0)
        report_mismatch("sync_timing", "blank rgb", 32'd0, 32'(o_rgb)); // Black in blanking
      if (o_tex_sclk !== 1'b1)
        report_mismatch("sync_timing", "sclk clk low", 32'd1, 32'(o_tex_sclk));
      #4; // Inside the high phase of clk
      if (o_tex_sclk !== 1'b0)
        report_mismatch("sync_timing", "sclk clk high", 32'd0, 32'(o_tex_sclk));
      if (h == rbz_timing_pkg::H_TOTAL - 10'd1) begin
        h = '0;
        v = (v == rbz_timing_pkg::V_TOTAL - 10'd1) ? 10'd0 : v + 10'd1;
      end else begin
        h = h + 10'd1;
      end
    end
    finish_test("sync_timing");
  endtask

  task automatic fetch_preamble_test();
    logic [31:0] exp_bits;
    int          count;
    setup_line(12'd512, 11'd1023);
    for (int i = 0; i < 1000; i++) begin
      @(negedge clk);
      if (!o_tex_csb) break;
    end
    if (o_tex_csb) abort_run("o_tex_csb never went low");
    if (o_hpos !== rbz_texture_pkg::TSPI_START)
      report_mismatch("fetch_preamble", "csb start", 32'(rbz_texture_pkg::TSPI_START), 32'(o_hpos));
    exp_bits = {rbz_texture_pkg::TSPI_READ_CMD, 9'd0, i_wall_id, i_side, i_texu, 6'd0};
    count = 0;
    while (!o_tex_csb && count < 400) begin
      if (count < 32) begin
        if (o_tex_out0 !== exp_bits[31])
          report_mismatch("fetch_preamble", "out0", 32'(exp_bits[31]), 32'(o_tex_out0));
        if (o_tex_oeb0 !== 1'b0)
          report_mismatch("fetch_preamble", "oeb0", 32'd0, 32'(o_tex_oeb0));
        exp_bits = exp_bits << 1; // MSB first
      end
      if (count == 32 && o_tex_oeb0 !== 1'b1)
        report_mismatch("fetch_preamble", "oeb0 at 32", 32'd1, 32'(o_tex_oeb0));
      count++;
      @(negedge clk);
    end
    if (count != 168) report_mismatch("fetch_preamble", "csb low clocks", 32'd168, 32'(count));
    finish_test("fetch_preamble");
  endtask

  task automatic unit_step_test();
    setup_line(12'd512, 11'd1023); // Whole line is wall
    check_line("unit_step");
    finish_test("unit_step");
  endtask

  task automatic scaled_step_test();
    logic [31:0] step;
    logic [31:0] size;
    repeat (3) begin
      take_bits(12, step);
      take_bits(11, size);
      setup_line(step[11:0], size[10:0]);
      check_line("scaled_step");
    end
    finish_test("scaled_step");
  endtask

  task automatic background_test();
    setup_line(12'd512, 11'd0);   // Floor and sky only
    check_line("background");
    setup_line(12'd512, 11'd100); // Edges at 270 and 369
    check_line("background");
    finish_test("background");
  endtask

  initial begin
    reset        = 1'b1;
    i_tex_in     = 4'hF;
    i_wall_id    = '0;
    i_side       = 1'b0;
    i_texu       = '0;
    i_wall_size  = '0;
    i_texa       = '0;
    i_sky        = 6'h2d; // Background shows outside blanking
    i_floor      = 6'h12;
    lfsr_state   = 32'h3e72;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    sync_timing_test();
    fetch_preamble_test();
    unit_step_test();
    scaled_step_test();
    background_test();
    $display("tests passed %0d failed %0d, assertion failures %0d", tests_passed, tests_failed,
             u_rbz_texture_top.u_tex_qspi_reader.u_rbz_texture_properties.fail_count);
    if (tests_failed == 0 &&
        u_rbz_texture_top.u_tex_qspi_reader.u_rbz_texture_properties.fail_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
